/* fill_dma.f */
+incdir+source
source/fill_dma_pkg.sv
source/burst_if.sv
source/wb_regs.sv
source/transfer_controller.sv
source/beat_writer.sv
source/dma_control.sv
source/fill_dma_top.sv
verif/tb_clock_gen.sv
verif/axi_mem_model.sv
verif/fill_checker.sv
verif/tb_fill_dma.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f fill_dma.f --top-module tb_fill_dma \
   -o tb_fill_dma && ./obj_dir/tb_fill_dma > sim.log 2>&1 || echo "sim failed" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

/* verif/tb_fill_dma.sv */
`timescale 1ns/10ps
`include "fill_dma_defines.svh"

module tb_fill_dma;

   logic        clk, rst;
   logic        wb_cyc, wb_stb, wb_we, wb_ack;
   logic [1:0]  wb_adr;
   logic [31:0] wb_dat_w, wb_dat_r;
   logic [31:0] awaddr;
   logic [7:0]  awlen;
   logic [2:0]  awsize;
   logic [1:0]  awburst;
   logic        awvalid, awready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wlast, wvalid, wready;
   logic [1:0]  bresp;
   logic        bvalid, bready;
   int          errors, tests;

   tb_clock_gen clock_gen (.*);
   fill_dma_top uut (.*);
   axi_mem_model mem (.*);
   fill_checker chk (.*);

   task automatic abort(input string why);
      $display("%s", why);
      $display("sim failed");
      $finish;
   endtask

   // One Wishbone classic cycle, held until ack
   task automatic bus_access(input logic we, input fill_dma_pkg::reg_sel_t sel,
                             input logic [31:0] wdat, output logic [31:0] rdat);
      int n;
      @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = sel;
      wb_dat_w = wdat;
      n = 0;
      @(negedge clk);
      while (!wb_ack) begin
         if (n == 16)
            abort("Wishbone ack did not arrive within 16 cycles");
         @(negedge clk);
         n++;
      end
      rdat   = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic reg_write(input fill_dma_pkg::reg_sel_t sel, input logic [31:0] data);
      logic [31:0] unused;
      bus_access(1'b1, sel, data, unused);
   endtask

   task automatic reg_read(input fill_dma_pkg::reg_sel_t sel, output logic [31:0] data);
      bus_access(1'b0, sel, 32'h0, data);
   endtask

   task automatic start_fill(input logic [31:0] addr, input logic [31:0] len,
                             input logic [7:0] key);
      reg_write(fill_dma_pkg::SEL_ADDR, addr);
      reg_write(fill_dma_pkg::SEL_LEN, len);
      reg_write(fill_dma_pkg::SEL_KEY, {24'h0, key});
      reg_write(fill_dma_pkg::SEL_CTRL, 32'h1);
   endtask

   task automatic wait_done(output logic [31:0] st);
      int polls;
      polls = 0;
      reg_read(fill_dma_pkg::SEL_CTRL, st);
      while (!st[`FILL_STAT_DONE]) begin
         if (polls == 4000)
            abort("fill did not finish within 4000 status polls");
         reg_read(fill_dma_pkg::SEL_CTRL, st);
         polls++;
      end
   endtask

   initial begin
      logic [31:0] st;
      int          n;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = 2'd0;
      wb_dat_w = 32'h0;
      n = 0;
      while (rst) begin
         if (n == 20)
            abort("reset was not released within 20 cycles");
         @(negedge clk);
         n++;
      end

      start_fill(32'h1000, 256, 8'h5A);
      wait_done(st);
      chk.check_value("aligned status", 32'h2, st & 32'h7);
      chk.check_fill("aligned", 32'h1000, 256, 8'h5A, 16);

      start_fill(32'h2003, 70, 8'hC3);
      wait_done(st);
      chk.check_fill("unaligned", 32'h2003, 70, 8'hC3, 8);

      start_fill(32'h3F9C, 3000, 8'h17);  // 100 bytes below the 4 KB line
      wait_done(st);
      chk.check_value("boundary status", 32'h2, st & 32'h7);
      chk.check_fill("boundary", 32'h3F9C, 3000, 8'h17, 16);

      start_fill(32'h5001, 2, 8'hA5);
      wait_done(st);
      chk.check_fill("sub word", 32'h5001, 2, 8'hA5, 8);

      start_fill(32'h7080, 512, 8'h3C);  // Covers the SLVERR window
      wait_done(st);
      chk.check_value("slave error status", 32'h6, st & 32'h7);
      chk.check_fill("slave error", 32'h7080, 512, 8'h3C, 16);
      start_fill(32'h8002, 301, 8'h99);
      reg_read(fill_dma_pkg::SEL_CTRL, st);
      chk.check_value("restart busy status", 32'h1, st & 32'h7);
      wait_done(st);
      chk.check_value("restart status", 32'h2, st & 32'h7);
      chk.check_fill("restart", 32'h8002, 301, 8'h99, 16);

      start_fill(32'h9000, 128, 8'h66);
      reg_write(fill_dma_pkg::SEL_ADDR, 32'h9100);  // All ignored while busy
      reg_write(fill_dma_pkg::SEL_LEN, 64);
      reg_write(fill_dma_pkg::SEL_KEY, 32'h77);
      reg_write(fill_dma_pkg::SEL_CTRL, 32'h1);
      wait_done(st);
      chk.check_value("busy start status", 32'h2, st & 32'h7);
      reg_read(fill_dma_pkg::SEL_ADDR, st);
      chk.check_value("busy start address", 32'h9000, st);
      chk.check_fill("busy start", 32'h9000, 128, 8'h66, 32'h200);

      $display("tests %0d, errors %0d", tests, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

/* verif/fill_checker.sv */
`timescale 1ns/10ps

module fill_checker (
   input  logic        clk,
   input  logic        rst,
   input  logic [31:0] awaddr,
   input  logic [7:0]  awlen,
   input  logic [2:0]  awsize,
   input  logic [1:0]  awburst,
   input  logic        awvalid,
   input  logic        awready,
   input  logic [31:0] wdata,
   input  logic [3:0]  wstrb,
   input  logic        wlast,
   input  logic        wvalid,
   input  logic        wready,
   output int          errors,
   output int          tests
);

   logic [7:0]  seen [logic [31:0]];  // Bytes the DUT put on W with strobe
   logic [31:0] beat_addr;
   logic [7:0]  beats_left;           // Beats of the burst after the current one
   logic [12:0] span_end;
   int          errors_seen;

   initial begin
      errors      = 0;
      tests       = 0;
      errors_seen = 0;
   end

   // Pattern inside the range, untouched memory outside
   function automatic logic [7:0] expected_byte(input logic [31:0] a, input logic [31:0] lo,
                                                input logic [31:0] len, input logic [7:0] key);
      if (a >= lo && a < lo + len)
         return a[7:0] ^ key;
      return 8'hEE;
   endfunction

   always @(posedge clk) begin
      if (!rst && awvalid && awready) begin
         beat_addr  <= awaddr;
         beats_left <= awlen;
         span_end = {1'b0, awaddr[11:0]} + {3'b000, awlen, 2'b00} + 13'd4;
         if (span_end > 13'h1000 || awaddr[1:0] != 2'b00) begin
            errors++;
            $display("AW burst at %h with awlen %0d is unaligned or crosses a 4 KB line",
                     awaddr, awlen);
         end
         if (awsize != 3'b010 || awburst != 2'b01) begin
            errors++;
            $display("AW burst at %h is not a 4 byte INCR burst, awsize %0d awburst %0d",
                     awaddr, awsize, awburst);
         end
      end
      if (!rst && wvalid && wready) begin
         for (int i = 0; i < 4; i++)
            if (wstrb[i])
               seen[beat_addr + 32'(i)] = wdata[8*i +: 8];
         if (wlast !== (beats_left == 8'd0)) begin
            errors++;
            $display("wlast was %b on the beat at %h with %0d beats of the burst still due",
                     wlast, beat_addr, beats_left);
         end
         beat_addr  <= beat_addr + 32'd4;
         beats_left <= beats_left - 8'd1;
      end
   end

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         errors++;
         $display("FAILED %s: expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_fill(input string name, input logic [31:0] lo, input logic [31:0] len,
                             input logic [7:0] key, input logic [31:0] margin);
      logic [31:0] a;
      logic [7:0]  exp;
      logic [7:0]  act;
      int          bad;
      bad = 0;
      for (a = lo - margin; a != lo + len + margin; a++) begin
         exp = expected_byte(a, lo, len, key);
         act = seen.exists(a) ? seen[a] : 8'hEE;
         if (exp !== act) begin
            if (bad == 0)
               $display("FAILED %s: byte %h expected %h actual %h", name, a, exp, act);
            bad++;
         end
      end
      errors += bad;
      tests++;
      if (errors == errors_seen)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d errors", name, errors - errors_seen);
      errors_seen = errors;
   endtask

endmodule

/* verif/axi_mem_model.sv */
`timescale 1ns/10ps

module axi_mem_model #(
   parameter logic [31:0] ERR_LO = 32'h0000_7100,  // Bytes answered with SLVERR
   parameter logic [31:0] ERR_HI = 32'h0000_713F
) (
   input  logic        clk,
   input  logic        rst,
   input  logic [31:0] awaddr,
   input  logic        awvalid,
   output logic        awready,
   input  logic [3:0]  wstrb,
   input  logic        wlast,
   input  logic        wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  logic        bready
);

   logic [31:0] waddr;
   logic [31:0] lane_addr;
   logic        resp_pend;
   logic        resp_err;

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         resp_pend <= 1'b0;
         resp_err  <= 1'b0;
      end else begin
         if (awvalid && awready)
            waddr <= awaddr;
         if (wvalid && wready) begin
            for (int i = 0; i < 4; i++) begin
               lane_addr = waddr + 32'(i);
               if (wstrb[i] && lane_addr >= ERR_LO && lane_addr <= ERR_HI)
                  resp_err <= 1'b1;  // Strobed byte inside the error window
            end
            waddr <= waddr + 32'd4;
            if (wlast)
               resp_pend <= 1'b1;
         end
         if (bvalid && bready) begin
            resp_pend <= 1'b0;
            resp_err  <= 1'b0;
         end
      end
   end

   // Ready stalls and response delay, all on the falling edge
   initial begin
      void'($urandom(32'h6266));
      awready = 1'b0;
      wready  = 1'b0;
      bvalid  = 1'b0;
      bresp   = 2'b00;
      forever begin
         @(negedge clk);
         awready = ($urandom % 4) != 0;
         wready  = ($urandom % 4) != 0;
         if (!bvalid) begin
            bvalid = resp_pend && (($urandom % 2) == 0);
            bresp  = resp_err ? 2'b10 : 2'b00;
         end else if (!resp_pend) begin
            bvalid = 1'b0;
         end
      end
   end

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;  // 8 ns period
   end

   initial begin
      rst = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

/* source/fill_dma_top.sv */
`timescale 1ns/10ps
`include "fill_dma_defines.svh"

module fill_dma_top (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    wb_cyc,
   input  logic                    wb_stb,
   input  logic                    wb_we,
   input  logic [1:0]              wb_adr,
   input  logic [`FILL_DATA_W-1:0] wb_dat_w,
   output logic [`FILL_DATA_W-1:0] wb_dat_r,
   output logic                    wb_ack,
   output logic [`FILL_ADDR_W-1:0] awaddr,
   output logic [7:0]              awlen,
   output logic [2:0]              awsize,
   output logic [1:0]              awburst,
   output logic                    awvalid,
   input  logic                    awready,
   output logic [`FILL_DATA_W-1:0] wdata,
   output logic [`FILL_STRB_W-1:0] wstrb,
   output logic                    wlast,
   output logic                    wvalid,
   input  logic                    wready,
   input  logic [1:0]              bresp,
   input  logic                    bvalid,
   output logic                    bready
);

   logic                    start;
   logic [`FILL_ADDR_W-1:0] fill_addr;
   logic [`FILL_LEN_W-1:0]  fill_len;
   logic [7:0]              fill_key;
   logic                    busy;
   logic                    done;
   logic                    error;
   logic                    transfer_start;
   logic                    burst_start;
   logic [`FILL_ADDR_W-1:0] axaddr;
   logic [7:0]              axlen;
   logic [`FILL_STRB_W-1:0] initial_strb;
   logic [`FILL_STRB_W-1:0] final_strb;
   logic                    last_transfer;

   burst_if bif ();

   wb_regs u_regs (
      .clk(clk), .rst(rst),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
      .start(start), .fill_addr(fill_addr), .fill_len(fill_len), .fill_key(fill_key),
      .busy(busy), .done(done), .error(error)
   );

   transfer_controller u_xfer (
      .clk(clk), .rst(rst),
      .address(fill_addr), .length(fill_len),
      .transfer_start(transfer_start), .burst_start(burst_start),
      .true_axi_axaddr(axaddr), .true_axi_axlen(axlen),
      .initial_strb(initial_strb), .final_strb(final_strb),
      .last_transfer(last_transfer)
   );

   dma_control u_ctrl (
      .clk(clk), .rst(rst),
      .start(start), .busy(busy), .done(done), .error(error),
      .transfer_start(transfer_start), .burst_start(burst_start),
      .axaddr(axaddr), .axlen(axlen),
      .initial_strb(initial_strb), .final_strb(final_strb), .last_transfer(last_transfer),
      .awaddr(awaddr), .awlen(awlen), .awsize(awsize), .awburst(awburst),
      .awvalid(awvalid), .awready(awready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .burst(bif)
   );

   beat_writer u_beats (
      .clk(clk), .rst(rst),
      .burst(bif),
      .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
      .fill_key(fill_key)
   );

endmodule

/* source/dma_control.sv */
`timescale 1ns/10ps
`include "fill_dma_defines.svh"

module dma_control (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    start,
   output logic                    busy,
   output logic                    done,            // Pulse on the final response
   output logic                    error,           // Pulse on a bad response
   output logic                    transfer_start,
   output logic                    burst_start,
   input  logic [`FILL_ADDR_W-1:0] axaddr,
   input  logic [7:0]              axlen,
   input  logic [`FILL_STRB_W-1:0] initial_strb,
   input  logic [`FILL_STRB_W-1:0] final_strb,
   input  logic                    last_transfer,
   output logic [`FILL_ADDR_W-1:0] awaddr,
   output logic [7:0]              awlen,
   output logic [2:0]              awsize,
   output logic [1:0]              awburst,
   output logic                    awvalid,
   input  logic                    awready,
   input  logic [1:0]              bresp,
   input  logic                    bvalid,
   output logic                    bready,
   burst_if.ctrl                   burst
);

   fill_dma_pkg::ctrl_state_t state;
   fill_dma_pkg::ctrl_state_t state_nxt;
   logic                      first_burst;
   logic                      final_burst;  // Burst in flight closes the transfer
   logic                      aw_fire;
   logic                      b_fire;

   assign aw_fire = awvalid & awready;
   assign b_fire  = bvalid & bready;

   always_comb begin
      state_nxt = state;
      case (state)
         fill_dma_pkg::ST_IDLE: if (start) state_nxt = fill_dma_pkg::ST_LOAD;
         fill_dma_pkg::ST_LOAD: state_nxt = fill_dma_pkg::ST_AW;
         fill_dma_pkg::ST_AW:   if (aw_fire) state_nxt = fill_dma_pkg::ST_DATA;
         fill_dma_pkg::ST_DATA: if (burst.burst_done) state_nxt = fill_dma_pkg::ST_RESP;
         fill_dma_pkg::ST_RESP:
            if (b_fire)
               state_nxt = final_burst ? fill_dma_pkg::ST_IDLE : fill_dma_pkg::ST_AW;
         default: state_nxt = fill_dma_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state       <= fill_dma_pkg::ST_IDLE;
         first_burst <= 1'b0;
         final_burst <= 1'b0;
      end else begin
         state <= state_nxt;
         if (transfer_start)
            first_burst <= 1'b1;
         else if (aw_fire)
            first_burst <= 1'b0;
         if (aw_fire)
            final_burst <= last_transfer;  // Controller moves on at this edge
      end
   end

   assign busy           = (state != fill_dma_pkg::ST_IDLE);
   assign transfer_start = (state == fill_dma_pkg::ST_LOAD);
   assign awvalid        = (state == fill_dma_pkg::ST_AW);
   assign bready         = (state == fill_dma_pkg::ST_RESP);
   assign burst_start    = aw_fire;

   // AW payload is the controller's registered state, steady until burst_start
   assign awaddr  = axaddr;
   assign awlen   = axlen;
   assign awsize  = 3'b010;  // 4 byte beats
   assign awburst = 2'b01;   // INCR

   assign burst.burst_go   = aw_fire;
   assign burst.beat_addr  = axaddr;
   assign burst.beat_len   = axlen;
   assign burst.first_strb = first_burst ? initial_strb : '1;
   assign burst.last_strb  = last_transfer ? final_strb : '1;

   assign done  = b_fire & final_burst;
   assign error = b_fire & (bresp != 2'b00);  // Anything but OKAY

endmodule

/* source/beat_writer.sv */
`timescale 1ns/10ps
`include "fill_dma_defines.svh"

module beat_writer (
   input  logic                    clk,
   input  logic                    rst,
   burst_if.writer                 burst,
   output logic [`FILL_DATA_W-1:0] wdata,
   output logic [`FILL_STRB_W-1:0] wstrb,
   output logic                    wlast,
   output logic                    wvalid,
   input  logic                    wready,
   input  logic [7:0]              fill_key
);

   logic [`FILL_ADDR_W-1:0] addr_q;      // Address of the beat on the bus
   logic [7:0]              beats_left;
   logic                    first_q;
   logic [`FILL_STRB_W-1:0] first_strb_q;
   logic [`FILL_STRB_W-1:0] last_strb_q;
   logic                    w_fire;

   assign w_fire = wvalid & wready;
   assign wlast  = wvalid & (beats_left == 8'd0);
   assign burst.burst_done = w_fire & wlast;

   always_comb begin
      for (int i = 0; i < `FILL_STRB_W; i++)
         wdata[8*i +: 8] = {addr_q[7:2], i[1:0]} ^ fill_key;  // Byte address XOR key
   end

   always_comb begin
      case ({first_q, wlast})
         2'b11:   wstrb = first_strb_q & last_strb_q;  // Single beat burst
         2'b10:   wstrb = first_strb_q;
         2'b01:   wstrb = last_strb_q;
         default: wstrb = '1;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wvalid     <= 1'b0;
         beats_left <= 8'd0;
         first_q    <= 1'b0;
      end else if (burst.burst_go) begin
         wvalid     <= 1'b1;
         beats_left <= burst.beat_len;
         first_q    <= 1'b1;
      end else if (w_fire) begin
         first_q <= 1'b0;
         if (wlast)
            wvalid <= 1'b0;
         else
            beats_left <= beats_left - 8'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (burst.burst_go) begin
         addr_q       <= burst.beat_addr;
         first_strb_q <= burst.first_strb;
         last_strb_q  <= burst.last_strb;
      end else if (w_fire) begin
         addr_q <= addr_q + `FILL_ADDR_W'(`FILL_STRB_W);
      end
   end

   w_hold: assert property (@(posedge clk) disable iff (rst)
      wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb));

endmodule

/* source/transfer_controller.sv */
`timescale 1ns/10ps
`include "fill_dma_defines.svh"

module transfer_controller (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [`FILL_ADDR_W-1:0] address,         // Held for the whole transfer
   input  logic [`FILL_LEN_W-1:0]  length,          // Bytes
   input  logic                    transfer_start,
   input  logic                    burst_start,     // AW of the current burst accepted
   output logic [`FILL_ADDR_W-1:0] true_axi_axaddr,
   output logic [7:0]              true_axi_axlen,
   output logic [`FILL_STRB_W-1:0] initial_strb,
   output logic [`FILL_STRB_W-1:0] final_strb,
   output logic                    last_transfer    // Pending burst ends the transfer
);

   logic [`FILL_LEN_W-1:0]  stored_len;  // Range bytes not yet covered
   logic                    first_transfer;
   logic                    loaded;
   logic [1:0]              lead;
   logic [1:0]              end_off;
   logic [12:0]             cap;
   logic [12:0]             byte_size;
   logic [12:0]             span_m1;
   logic [9:0]              beats;
   logic [`FILL_ADDR_W-1:0] next_addr;
   logic [`FILL_LEN_W-1:0]  next_len;

   // Range bytes one burst can carry from a word aligned page offset
   function automatic logic [12:0] burst_cap(input logic [11:0] page_off, input logic [1:0] skip);
      logic [12:0] to_boundary;
      logic [12:0] room;
      to_boundary = 13'h1000 - {1'b0, page_off};
      room = (to_boundary < 13'h0400) ? to_boundary : 13'h0400;  // 256 beats of 4 bytes
      return room - {11'b0, skip};
   endfunction

   assign lead    = first_transfer ? address[1:0] : 2'b00;  // Dead lanes before the start byte
   assign cap     = burst_cap(true_axi_axaddr[11:0], lead);
   assign byte_size = (stored_len < cap) ? stored_len[12:0] : cap;
   assign span_m1 = byte_size + {11'b0, lead} - 13'd1;
   assign true_axi_axlen = span_m1[9:2];
   assign beats   = {2'b00, true_axi_axlen} + 10'd1;

   assign next_addr = true_axi_axaddr + {{(`FILL_ADDR_W-12){1'b0}}, beats, 2'b00};
   assign next_len  = stored_len - {{(`FILL_LEN_W-13){1'b0}}, byte_size};

   assign end_off = address[1:0] + length[1:0] - 2'd1;  // Lane of the final byte

   always_comb begin
      for (int i = 0; i < `FILL_STRB_W; i++) begin
         initial_strb[i] = (i >= address[1:0]);
         final_strb[i]   = (i <= end_off);
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         true_axi_axaddr <= '0;
         stored_len      <= '0;
         first_transfer  <= 1'b0;
         loaded          <= 1'b0;
         last_transfer   <= 1'b0;
      end else if (transfer_start) begin
         true_axi_axaddr <= {address[`FILL_ADDR_W-1:2], 2'b00};
         stored_len      <= length;
         first_transfer  <= 1'b1;
         loaded          <= 1'b1;
         last_transfer   <= length <= burst_cap({address[11:2], 2'b00}, address[1:0]);
      end else if (burst_start && loaded) begin
         true_axi_axaddr <= next_addr;
         stored_len      <= next_len;
         first_transfer  <= 1'b0;
         // Look one burst ahead, next_addr is aligned
         last_transfer   <= next_len <= burst_cap(next_addr[11:0], 2'b00);
         if (last_transfer)
            loaded <= 1'b0;
      end
   end

   burst_needs_load: assert property (@(posedge clk) disable iff (rst) burst_start |-> loaded);

endmodule

/* source/wb_regs.sv */
`timescale 1ns/10ps
`include "fill_dma_defines.svh"

module wb_regs (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    wb_cyc,
   input  logic                    wb_stb,
   input  logic                    wb_we,
   input  logic [1:0]              wb_adr,
   input  logic [`FILL_DATA_W-1:0] wb_dat_w,
   output logic [`FILL_DATA_W-1:0] wb_dat_r,
   output logic                    wb_ack,
   output logic                    start,
   output logic [`FILL_ADDR_W-1:0] fill_addr,
   output logic [`FILL_LEN_W-1:0]  fill_len,
   output logic [7:0]              fill_key,
   input  logic                    busy,
   input  logic                    done,
   input  logic                    error
);

   fill_dma_pkg::reg_sel_t  sel;
   logic                    req;
   logic                    wr;
   logic                    locked;
   logic                    done_q;
   logic                    error_q;
   logic [`FILL_DATA_W-1:0] status;

   assign sel    = fill_dma_pkg::reg_sel_t'(wb_adr);
   assign req    = wb_cyc & wb_stb & ~wb_ack;  // Not yet answered
   assign wr     = req & wb_we;
   assign locked = busy | start;               // Running or about to

   always_comb begin
      status = '0;
      status[`FILL_STAT_BUSY] = locked;
      status[`FILL_STAT_DONE] = done_q;
      status[`FILL_STAT_ERR]  = error_q;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wb_ack    <= 1'b0;
         start     <= 1'b0;
         fill_addr <= '0;
         fill_len  <= '0;
         fill_key  <= '0;
      end else begin
         wb_ack <= req;
         start  <= wr && (sel == fill_dma_pkg::SEL_CTRL) && wb_dat_w[`FILL_CTRL_GO] && !locked;
         // Setup stays frozen for the whole fill
         if (wr && !locked) begin
            case (sel)
               fill_dma_pkg::SEL_ADDR: fill_addr <= wb_dat_w;
               fill_dma_pkg::SEL_LEN:  fill_len  <= wb_dat_w[`FILL_LEN_W-1:0];
               fill_dma_pkg::SEL_KEY:  fill_key  <= wb_dat_w[7:0];
               default: ;
            endcase
         end
      end
   end

   // Sticky flags, a new start wipes both
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done_q  <= 1'b0;
         error_q <= 1'b0;
      end else if (start) begin
         done_q  <= 1'b0;
         error_q <= 1'b0;
      end else begin
         if (done)
            done_q <= 1'b1;
         if (error)
            error_q <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (req) begin
         case (sel)
            fill_dma_pkg::SEL_ADDR: wb_dat_r <= fill_addr;
            fill_dma_pkg::SEL_LEN:  wb_dat_r <= {{(`FILL_DATA_W-`FILL_LEN_W){1'b0}}, fill_len};
            fill_dma_pkg::SEL_KEY:  wb_dat_r <= {{(`FILL_DATA_W-8){1'b0}}, fill_key};
            default:                wb_dat_r <= status;
         endcase
      end
   end

   ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack);

endmodule

/* source/burst_if.sv */
`timescale 1ns/10ps
`include "fill_dma_defines.svh"

interface burst_if;

   logic                     burst_go;    // Single cycle, AW accepted
   logic [`FILL_ADDR_W-1:0]  beat_addr;   // Word aligned
   logic [7:0]               beat_len;    // Beats minus one
   logic [`FILL_STRB_W-1:0]  first_strb;
   logic [`FILL_STRB_W-1:0]  last_strb;
   logic                     burst_done;  // Last beat taken by the slave

   modport ctrl (
      output burst_go,
      output beat_addr,
      output beat_len,
      output first_strb,
      output last_strb,
      input  burst_done
   );

   modport writer (
      input  burst_go,
      input  beat_addr,
      input  beat_len,
      input  first_strb,
      input  last_strb,
      output burst_done
   );

endinterface

/* source/fill_dma_pkg.sv */
`include "fill_dma_defines.svh"

package fill_dma_pkg;

   // Sequencer states, one burst in flight at a time
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LOAD,   // Transfer controller takes address and length
      ST_AW,     // Address phase of the current burst
      ST_DATA,   // Beats running on W
      ST_RESP    // Waiting for B
   } ctrl_state_t;

   // Register select, values follow the word offsets
   typedef enum logic [1:0] {
      SEL_ADDR = `FILL_REG_ADDR,
      SEL_LEN  = `FILL_REG_LEN,
      SEL_KEY  = `FILL_REG_KEY,
      SEL_CTRL = `FILL_REG_CTRL
   } reg_sel_t;

endpackage

/* source/fill_dma_defines.svh */
`ifndef FILL_DMA_DEFINES_SVH
`define FILL_DMA_DEFINES_SVH

`define FILL_ADDR_W 32
`define FILL_DATA_W 32
`define FILL_LEN_W  24
`define FILL_STRB_W (`FILL_DATA_W/8)

// Word offsets on the Wishbone port
`define FILL_REG_ADDR 2'd0
`define FILL_REG_LEN  2'd1
`define FILL_REG_KEY  2'd2
`define FILL_REG_CTRL 2'd3

// Control write and status read bits
`define FILL_CTRL_GO   0
`define FILL_STAT_BUSY 0
`define FILL_STAT_DONE 1
`define FILL_STAT_ERR  2

`endif
